// ==== Bender.yml ====
package:
  name: rect_demo

sources:
  - include_dirs:
      - .
    files:
      - video_pkg.sv
      - draw_pkg.sv
      - display_timing.sv
      - shape_sequencer.sv
      - rect_raster.sv
      - framebuffer.sv
      - palette_out.sv
      - rect_top.sv
      - target: test
        files:
          - tb_rect_top.sv

// ==== display_timing.sv ====
/*
 * display timing generator
 * raster position, active low syncs, data enable, frame and line pulses
 */
`timescale 1ns/10ps
`include "rect_defs.svh"

module display_timing import draw_pkg::*; (
    input  logic   clk_pix,
    input  logic   arst_n,
    output coord_t sx,     // column
    output coord_t sy,     // row
    output logic   hsync,
    output logic   vsync,
    output logic   de,     // visible area
    output logic   frame,  // start of frame
    output logic   line    // start of row
);

    coord_t nx;  // next column
    coord_t ny;  // next row

    always_comb begin
        if (sx == `H_TOTAL - 1) begin  // wrap to next row
            nx = '0;
            ny = (sy == `V_TOTAL - 1) ? '0 : sy + 16'sd1;
        end else begin
            nx = sx + 16'sd1;
            ny = sy;
        end
    end

    // all outputs registered from the next position so they stay aligned
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= coord_t'(`H_TOTAL - 1);  // first edge lands on 0,0
            sy    <= coord_t'(`V_TOTAL - 1);
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= nx;
            sy    <= ny;
            hsync <= !(nx >= `H_ACTIVE + `H_FP &&
                       nx < `H_ACTIVE + `H_FP + `H_SYNC);  // low in sync
            vsync <= !(ny >= `V_ACTIVE + `V_FP &&
                       ny < `V_ACTIVE + `V_FP + `V_SYNC);
            de    <= (nx < `H_ACTIVE) && (ny < `V_ACTIVE);
            frame <= (nx == 0) && (ny == 0);
            line  <= (nx == 0);
        end
    end

endmodule

// ==== draw_pkg.sv ====
/*
 * drawing side types
 * coordinates, rasterizer opcodes and sequencer states
 */
package draw_pkg;

    typedef logic signed [15:0] coord_t;  // screen and framebuffer position

    // rasterizer operation
    typedef enum logic {
        OP_FILL,     // every pixel inside the corners
        OP_OUTLINE   // edge pixels only
    } raster_op_e;

    // shape sequencer states
    typedef enum logic [2:0] {
        S_IDLE,        // wait for first frame
        S_CLEAR,       // send full screen fill
        S_WAIT_CLEAR,  // fill in progress
        S_ISSUE,       // send next outline
        S_WAIT_SHAPE,  // outline in progress
        S_DONE         // all shapes drawn
    } seq_state_e;

endpackage

// ==== framebuffer.sv ====
/*
 * indexed colour framebuffer
 * write queue with credit return, single port memory, 2x letterboxed readout
 */
`timescale 1ns/10ps
`include "rect_defs.svh"

module framebuffer import draw_pkg::*, video_pkg::*; (
    input  logic   clk_pix,
    input  logic   arst_n,
    input  coord_t sx,
    input  coord_t sy,
    input  logic   de,
    input  logic   wr_valid,
    input  coord_t wr_x,
    input  coord_t wr_y,
    input  cidx_t  wr_cidx,
    output logic   credit,   // pulse per queue entry retired
    output cidx_t  pix_cidx  // one cycle after sx, sy
);

    cidx_t              mem [`FB_WIDTH * `FB_HEIGHT];
    logic [`FB_AW-1:0]  q_addr [`FB_QDEPTH];  // queued write address
    cidx_t              q_cidx [`FB_QDEPTH];  // queued write colour
    logic [`FB_QPW-1:0] wp, rp;
    logic [`FB_QCW-1:0] q_cnt;
    logic               in_band;
    logic               rd_need;  // display owns the port this cycle
    logic               pop;
    coord_t             fx, fy;   // framebuffer position of sx, sy
    logic [`FB_AW-1:0]  raddr;

    assign in_band = de && (sy >= `LB_TOP) && (sy < `LB_TOP + `FB_HEIGHT * `FB_SCALE);
    assign rd_need = in_band && (sx % `FB_SCALE == 0);  // first of each pair
    assign pop     = (q_cnt != '0) && !rd_need;         // free cycle
    assign fx      = coord_t'(sx / `FB_SCALE);
    assign fy      = coord_t'((sy - `LB_TOP) / `FB_SCALE);
    assign raddr   = `FB_AW'(fy * `FB_WIDTH + fx);

    // queue storage
    always_ff @(posedge clk_pix) begin
        if (wr_valid) begin
            q_addr[wp] <= `FB_AW'(wr_y * `FB_WIDTH + wr_x);
            q_cidx[wp] <= wr_cidx;
        end
    end

    // queue pointers and count
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            wp     <= '0;
            rp     <= '0;
            q_cnt  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;  // slot freed
            if (wr_valid) wp <= (wp == `FB_QDEPTH - 1) ? '0 : wp + 1'b1;
            if (pop) rp <= (rp == `FB_QDEPTH - 1) ? '0 : rp + 1'b1;
            case ({wr_valid, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // memory write, only when the display leaves the port free
    always_ff @(posedge clk_pix) begin
        if (pop) mem[q_addr[rp]] <= q_cidx[rp];
    end

    // display read, held across the second cycle of each pair
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            pix_cidx <= '0;
        end else if (rd_need) begin
            pix_cidx <= mem[raddr];
        end else if (!in_band) begin
            pix_cidx <= '0;  // border and blanking
        end
    end

    // credit loop keeps the rasterizer from overrunning the queue
    assert property (@(posedge clk_pix) disable iff (!arst_n)
        wr_valid |-> (q_cnt < `FB_QDEPTH) || pop);

endmodule

// ==== palette_out.sv ====
/*
 * palette output stage
 * colour lookup plus two cycle sync and de alignment
 */
`timescale 1ns/10ps

module palette_out import video_pkg::*; (
    input  logic  clk_pix,
    input  logic  arst_n,
    input  logic  hsync_in,
    input  logic  vsync_in,
    input  logic  de_in,
    input  cidx_t pix_cidx,  // lags the syncs by one
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output chan_t red,
    output chan_t green,
    output chan_t blue
);

    logic hs_d, vs_d, de_d;  // first delay stage, lines up with pix_cidx

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hs_d  <= 1'b1;
            vs_d  <= 1'b1;
            de_d  <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hs_d  <= hsync_in;
            vs_d  <= vsync_in;
            de_d  <= de_in;
            hsync <= hs_d;
            vsync <= vs_d;
            de    <= de_d;
            red   <= de_d ? palette_lut[pix_cidx].r : '0;  // black in blanking
            green <= de_d ? palette_lut[pix_cidx].g : '0;
            blue  <= de_d ? palette_lut[pix_cidx].b : '0;
        end
    end

endmodule

// ==== rect_defs.svh ====
/*
 * rectangle demo shared defines
 * raster timing, framebuffer geometry, letterbox, write queue and shape set
 */
`ifndef RECT_DEFS_SVH
`define RECT_DEFS_SVH

`define H_ACTIVE  160  // visible columns
`define H_FP      8    // horizontal front porch
`define H_SYNC    16   // hsync width, active low
`define H_BP      8    // horizontal back porch
`define H_TOTAL   (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

`define V_ACTIVE  100  // visible rows
`define V_FP      2    // vertical front porch
`define V_SYNC    2    // vsync width in rows, active low
`define V_BP      2    // vertical back porch
`define V_TOTAL   (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

`define FB_WIDTH  80   // framebuffer columns
`define FB_HEIGHT 45   // framebuffer rows
`define FB_SCALE  2    // display pixels per framebuffer pixel, both axes
`define FB_AW     12   // address bits for FB_WIDTH * FB_HEIGHT entries
`define LB_TOP    5    // first display row of the letterbox band

`define FB_QDEPTH 4    // write queue depth, also initial credits
`define FB_QPW    2    // queue pointer width
`define FB_QCW    3    // queue count and credit counter width

`define SHAPE_CNT 16   // rectangles after the clear
`define SHAPE_X0  10   // shape 0 corners, each later shape shrinks by one
`define SHAPE_Y0  4
`define SHAPE_X1  69
`define SHAPE_Y1  40

`endif

// ==== rect_raster.sv ====
/*
 * rectangle rasterizer
 * scans a filled or outline rectangle into credit paced pixel writes
 */
`timescale 1ns/10ps
`include "rect_defs.svh"

module rect_raster import draw_pkg::*, video_pkg::*; (
    input  logic       clk_pix,
    input  logic       arst_n,
    input  logic       cmd_start,
    input  raster_op_e cmd_op,
    input  coord_t     cmd_x0,
    input  coord_t     cmd_y0,
    input  coord_t     cmd_x1,
    input  coord_t     cmd_y1,
    input  cidx_t      cmd_cidx,
    input  logic       credit,    // one queue slot freed
    output logic       idle,
    output logic       done,
    output logic       wr_valid,
    output coord_t     wr_x,
    output coord_t     wr_y,
    output cidx_t      wr_cidx
);

    logic              busy;
    raster_op_e        op;
    coord_t            x0, y0, x1, y1;  // latched corners
    coord_t            px, py;          // scan position
    cidx_t             cidx;
    logic [`FB_QCW-1:0] cnt;            // credits held
    logic              issue;
    logic              last_col, last_row, inner_row;

    assign idle      = !busy;
    assign issue     = busy && (cnt != '0);  // stall at zero credits
    assign last_col  = (px == x1);
    assign last_row  = (py == y1);
    assign inner_row = (py != y0) && !last_row;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            wr_valid <= 1'b0;
            px       <= '0;
            py       <= '0;
        end else begin
            done     <= 1'b0;
            wr_valid <= issue;
            if (!busy) begin
                if (cmd_start) begin  // start at top left
                    busy <= 1'b1;
                    px   <= cmd_x0;
                    py   <= cmd_y0;
                end
            end else if (issue) begin
                if (last_col) begin
                    if (last_row) begin
                        busy <= 1'b0;
                        done <= 1'b1;  // with the last write
                    end else begin
                        px <= x0;
                        py <= py + 16'sd1;
                    end
                end else if (op == OP_OUTLINE && inner_row && px == x0) begin
                    px <= x1;  // skip interior
                end else begin
                    px <= px + 16'sd1;
                end
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (cmd_start && !busy) begin
            op   <= cmd_op;
            x0   <= cmd_x0;
            y0   <= cmd_y0;
            x1   <= cmd_x1;
            y1   <= cmd_y1;
            cidx <= cmd_cidx;
        end
        if (issue) begin  // write payload
            wr_x    <= px;
            wr_y    <= py;
            wr_cidx <= cidx;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= `FB_QCW'(`FB_QDEPTH);
        end else begin
            case ({issue, credit})
                2'b10:   cnt <= cnt - 1'b1;
                2'b01:   cnt <= cnt + 1'b1;
                default: cnt <= cnt;  // none or both
            endcase
        end
    end

    // sequencer only starts us when idle
    assert property (@(posedge clk_pix) disable iff (!arst_n) cmd_start |-> !busy);
    // returned credits never exceed the queue depth
    assert property (@(posedge clk_pix) disable iff (!arst_n) cnt <= `FB_QDEPTH);

endmodule

// ==== rect_top.sv ====
/*
 * nested rectangles demo top
 * timing, sequencer, rasterizer, framebuffer and palette stage
 */
`timescale 1ns/10ps

module rect_top import draw_pkg::*, video_pkg::*; (
    input  logic  clk_pix,
    input  logic  arst_n,
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output chan_t red,
    output chan_t green,
    output chan_t blue,
    output logic  draw_done
);

    coord_t     sx, sy;                   // raster position
    logic       hsync_raw, vsync_raw, de_raw;  // before alignment
    logic       frame;
    logic       cmd_start, idle, done;
    raster_op_e cmd_op;
    coord_t     cmd_x0, cmd_y0, cmd_x1, cmd_y1;
    cidx_t      cmd_cidx;
    logic       wr_valid, credit;
    coord_t     wr_x, wr_y;
    cidx_t      wr_cidx;
    cidx_t      pix_cidx;

    display_timing u_timing (
        .clk_pix, .arst_n, .sx, .sy,
        .hsync(hsync_raw), .vsync(vsync_raw), .de(de_raw), .frame, .line()
    );

    shape_sequencer u_seq (
        .clk_pix, .arst_n, .frame, .idle, .done, .cmd_start, .cmd_op,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_cidx, .draw_done
    );

    rect_raster u_raster (
        .clk_pix, .arst_n, .cmd_start, .cmd_op, .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1,
        .cmd_cidx, .credit, .idle, .done, .wr_valid, .wr_x, .wr_y, .wr_cidx
    );

    framebuffer u_fb (
        .clk_pix, .arst_n, .sx, .sy, .de(de_raw), .wr_valid, .wr_x, .wr_y, .wr_cidx,
        .credit, .pix_cidx
    );

    palette_out u_pal (
        .clk_pix, .arst_n, .hsync_in(hsync_raw), .vsync_in(vsync_raw), .de_in(de_raw),
        .pix_cidx, .hsync, .vsync, .de, .red, .green, .blue
    );

endmodule

// ==== shape_sequencer.sv ====
/*
 * shape sequencer
 * clears the framebuffer then issues one outline command per rectangle
 */
`timescale 1ns/10ps
`include "rect_defs.svh"

module shape_sequencer import draw_pkg::*, video_pkg::*; (
    input  logic       clk_pix,
    input  logic       arst_n,
    input  logic       frame,      // start of frame
    input  logic       idle,       // rasterizer ready
    input  logic       done,       // rasterizer finished
    output logic       cmd_start,
    output raster_op_e cmd_op,
    output coord_t     cmd_x0,
    output coord_t     cmd_y0,
    output coord_t     cmd_x1,
    output coord_t     cmd_y1,
    output cidx_t      cmd_cidx,
    output logic       draw_done   // sticky
);

    seq_state_e state;
    coord_t     shape_k;  // current shape number

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            shape_k   <= '0;
            cmd_start <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            cmd_start <= 1'b0;  // single cycle pulse
            case (state)
                S_IDLE: begin
                    if (frame) state <= S_CLEAR;
                end
                S_CLEAR: begin
                    if (idle) begin
                        cmd_start <= 1'b1;
                        state     <= S_WAIT_CLEAR;
                    end
                end
                S_WAIT_CLEAR: begin
                    if (done) state <= S_ISSUE;
                end
                S_ISSUE: begin
                    if (idle) begin
                        cmd_start <= 1'b1;
                        state     <= S_WAIT_SHAPE;
                    end
                end
                S_WAIT_SHAPE: begin
                    if (done) begin
                        if (shape_k == `SHAPE_CNT - 1) begin
                            state <= S_DONE;
                        end else begin
                            shape_k <= shape_k + 16'sd1;
                            state   <= S_ISSUE;
                        end
                    end
                end
                S_DONE: draw_done <= 1'b1;
                default: state <= S_IDLE;
            endcase
        end
    end

    // command fields load with the start pulse and hold until the next one
    always_ff @(posedge clk_pix) begin
        if (state == S_CLEAR && idle) begin  // whole framebuffer in black
            cmd_op   <= OP_FILL;
            cmd_x0   <= '0;
            cmd_y0   <= '0;
            cmd_x1   <= coord_t'(`FB_WIDTH - 1);
            cmd_y1   <= coord_t'(`FB_HEIGHT - 1);
            cmd_cidx <= '0;
        end else if (state == S_ISSUE && idle) begin  // nested outlines
            cmd_op   <= OP_OUTLINE;
            cmd_x0   <= coord_t'(`SHAPE_X0) + shape_k;
            cmd_y0   <= coord_t'(`SHAPE_Y0) + shape_k;
            cmd_x1   <= coord_t'(`SHAPE_X1) - shape_k;
            cmd_y1   <= coord_t'(`SHAPE_Y1) - shape_k;
            cmd_cidx <= cidx_t'(shape_k[3:0]);  // colour wraps every 16
        end
    end

endmodule

// ==== src.f ====
+incdir+.
video_pkg.sv
draw_pkg.sv
display_timing.sv
shape_sequencer.sv
rect_raster.sv
framebuffer.sv
palette_out.sv
rect_top.sv
tb_rect_top.sv

// ==== tb_rect_top.sv ====
/*
 * testbench for the nested rectangles demo
 * checks raster timing, blanking, drawing completion and one full frame
 */
`timescale 1ns/10ps
`include "rect_defs.svh"

module tb_rect_top import draw_pkg::*, video_pkg::*;;

    localparam int BAND_END    = `LB_TOP + `FB_HEIGHT * `FB_SCALE;  // first row below band
    localparam int TIMEOUT_CYC = 8 * `H_TOTAL * `V_TOTAL;           // 8 frames

    logic  clk_pix = 1'b0;
    logic  arst_n  = 1'b0;  // held from time zero
    logic  hsync, vsync, de, draw_done;
    chan_t red, green, blue;

    logic  mon_en     = 1'b0;  // monitor runs once reset is gone
    logic  hs_q       = 1'b1;  // previous samples for edge detect
    logic  vs_q       = 1'b1;
    logic  de_q       = 1'b0;
    logic  row_ok     = 1'b0;  // row known after first vsync
    logic  checking   = 1'b0;  // inside the compared frame
    logic  frame_done = 1'b0;
    logic  seen_done  = 1'b0;
    int    hs_len     = 0;
    int    vs_len     = 0;
    int    de_len     = 0;
    int    row_cnt    = 0;     // de rows since last vsync
    int    row        = 0;
    int    col        = 0;
    int    pix_cnt    = 0;
    int    cycles     = 0;
    rgb_t  exp_rgb;

    rect_top UUT (
        .clk_pix, .arst_n, .hsync, .vsync, .de, .red, .green, .blue, .draw_done
    );

    always #5 clk_pix = ~clk_pix;  // 10 ns period

    // colour index at a framebuffer position, later outlines overwrite earlier ones
    function automatic cidx_t ref_cidx(int fx, int fy);
        cidx_t c;
        int    x0, y0, x1, y1;
        c = 4'h0;  // cleared framebuffer
        for (int k = 0; k < `SHAPE_CNT; k++) begin
            x0 = `SHAPE_X0 + k;
            y0 = `SHAPE_Y0 + k;
            x1 = `SHAPE_X1 - k;
            y1 = `SHAPE_Y1 - k;
            if (fx >= x0 && fx <= x1 && fy >= y0 && fy <= y1 &&
                (fx == x0 || fx == x1 || fy == y0 || fy == y1)) begin
                c = cidx_t'(k % 16);
            end
        end
        return c;
    endfunction

    // expected colour at a visible display position
    function automatic rgb_t ref_rgb(int dx, int dy);
        rgb_t c;
        if (dy < `LB_TOP || dy >= BAND_END) begin
            c = palette_lut[0];  // letterbox border
        end else begin
            c = palette_lut[ref_cidx(dx / `FB_SCALE, (dy - `LB_TOP) / `FB_SCALE)];
        end
        return c;
    endfunction

    task automatic check_chan(string name, chan_t exp, chan_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "colour channel mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "sync or enable mismatch");
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "timing length mismatch");
        end
    endtask

    always @(posedge clk_pix) mon_en <= arst_n;  // enable lands between falling edges

    // output monitor, samples on falling edges where outputs are stable
    always @(negedge clk_pix) begin
        if (mon_en) begin
            if (!de) begin  // blanking is black
                check_chan("red", 4'h0, red);
                check_chan("green", 4'h0, green);
                check_chan("blue", 4'h0, blue);
            end else if (row_ok && (row < `LB_TOP || row >= BAND_END)) begin
                check_chan("red", 4'h0, red);  // letterbox border
                check_chan("green", 4'h0, green);
                check_chan("blue", 4'h0, blue);
            end
            if (de && checking) begin  // full frame compare
                exp_rgb = ref_rgb(col, row);
                check_chan($sformatf("red at %0d,%0d", col, row), exp_rgb.r, red);
                check_chan($sformatf("green at %0d,%0d", col, row), exp_rgb.g, green);
                check_chan($sformatf("blue at %0d,%0d", col, row), exp_rgb.b, blue);
                pix_cnt++;
            end
            if (de && row_ok) col++;
            if (!hsync) hs_len++;
            if (!vsync) vs_len++;
            if (de) de_len++;
            if (de && !de_q) row_cnt++;
            if (!de && de_q) begin  // end of a visible row
                check_count("de cycles per row", `H_ACTIVE, de_len);
                de_len = 0;
            end
            if (hsync && !hs_q) begin  // back porch starts, next row follows
                check_count("hsync low cycles", `H_SYNC, hs_len);
                hs_len = 0;
                row    = (row == `V_TOTAL - 1) ? 0 : row + 1;
                col    = 0;
            end
            if (!vsync && vs_q) begin
                check_count("de rows per frame", `V_ACTIVE, row_cnt);
                row_cnt = 0;
            end
            if (vsync && !vs_q) begin  // vertical back porch, frame start
                check_count("vsync low cycles", `V_SYNC * `H_TOTAL, vs_len);
                vs_len = 0;
                row    = `V_ACTIVE + `V_FP + `V_SYNC;
                row_ok = 1'b1;
                if (checking) begin
                    checking   = 1'b0;
                    frame_done = 1'b1;
                end else if (draw_done && !frame_done) begin
                    checking = 1'b1;  // first frame with drawing finished
                    pix_cnt  = 0;
                end
            end
            if (seen_done) check_bit("draw_done", 1'b1, draw_done);  // sticky
            if (draw_done) seen_done = 1'b1;
            hs_q = hsync;
            vs_q = vsync;
            de_q = de;
        end
    end

    // run limit
    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles without a complete frame check", cycles);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped at the cycle limit");
        end
    end

    initial begin
        repeat (4) @(negedge clk_pix);
        check_bit("hsync", 1'b1, hsync);  // idle outputs before counting starts
        check_bit("vsync", 1'b1, vsync);
        check_bit("de", 1'b0, de);
        check_bit("draw_done", 1'b0, draw_done);
        check_chan("red", 4'h0, red);
        check_chan("green", 4'h0, green);
        check_chan("blue", 4'h0, blue);
        arst_n = 1'b1;  // release on falling edge
        wait (frame_done);
        if (pix_cnt == `H_ACTIVE * `V_ACTIVE) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("frame compare covered %0d pixels instead of %0d",
                     pix_cnt, `H_ACTIVE * `V_ACTIVE);
            $display("TEST FAILED");
            $fatal(1, "incomplete frame compare");
        end
    end

endmodule

// ==== video_pkg.sv ====
/*
 * display side types and the fixed 16 colour palette
 */
package video_pkg;

    typedef logic [3:0] chan_t;  // one colour channel
    typedef logic [3:0] cidx_t;  // framebuffer colour index

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    localparam rgb_t palette_lut [16] = '{
        '{4'h0, 4'h0, 4'h0}, '{4'h1, 4'h2, 4'h5}, '{4'h7, 4'h2, 4'h5}, '{4'h0, 4'h8, 4'h5},
        '{4'hA, 4'h5, 4'h3}, '{4'h5, 4'h5, 4'h4}, '{4'hC, 4'hC, 4'hC}, '{4'hF, 4'hF, 4'hE},
        '{4'hF, 4'h0, 4'h4}, '{4'hF, 4'hA, 4'h0}, '{4'hF, 4'hE, 4'h2}, '{4'h0, 4'hE, 4'h3},
        '{4'h2, 4'hA, 4'hF}, '{4'h8, 4'h7, 4'h9}, '{4'hF, 4'h7, 4'hA}, '{4'hF, 4'hC, 4'hA}
    };  // entry 0 black

endpackage
